// File: rtl/calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Operand and result width
`define CALC_DATA_WIDTH 16

// Operand memory geometry
`define CALC_MEM_DEPTH 16
`define CALC_ADDR_WIDTH 4

// Fixed slots in the operand memory
`define CALC_OPERAND_A_ADDR 0
`define CALC_OPERAND_B_ADDR 1
`define CALC_RESULT_ADDR 2

`endif

// File: rtl/calc_pkg.sv
`default_nettype none

`include "calc_macros.svh"

package calc_pkg;

    typedef logic [`CALC_DATA_WIDTH-1:0] word_t;      // One data word
    typedef logic [3:0]                  digit_t;     // Decimal key, 0 to 9
    typedef logic [`CALC_ADDR_WIDTH-1:0] mem_addr_t;  // Word address

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } calc_op_t;

    typedef enum logic {
        ENTRY_OPERATOR,
        ENTRY_EQUAL
    } entry_kind_t;

    // One completed operand from the keypad
    typedef struct packed {
        entry_kind_t kind;
        calc_op_t    op;
        word_t       value;
    } entry_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        mem_addr_t adr;
        word_t     dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        GET_FIRST,
        WRITE_A,
        GET_SECOND,
        WRITE_B,
        READ_A,
        READ_B,
        CALC,
        WRITE_RESULT,
        SHOW
    } ctl_state_t;

endpackage

`default_nettype wire

// File: rtl/key_entry.sv
`timescale 1ns/10ps
`default_nettype none

module key_entry
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     busy,         // Controller is working, drop keys
    input  logic     key_valid,
    input  digit_t   key_digit,
    input  logic     op_valid,
    input  calc_op_t op_code,
    input  logic     equal_valid,
    output logic     entry_valid,  // One cycle per operator or equal key
    output entry_t   entry
);

    word_t acc_q;  // Operand being typed

    // Accumulator and event strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q       <= '0;
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= 1'b0;
            if (!busy) begin
                if (op_valid || equal_valid) begin
                    entry_valid <= 1'b1;
                    acc_q       <= '0;  // Next operand starts fresh
                end else if (key_valid) begin
                    // Times ten as 8x + 2x, wraps at 16 bits
                    acc_q <= (acc_q << 3) + (acc_q << 1) + word_t'(key_digit);
                end
            end
        end
    end

    // Event payload
    always_ff @(posedge clk) begin
        if (!busy && (op_valid || equal_valid)) begin
            entry.value <= acc_q;
            entry.op    <= op_code;
            if (op_valid) begin
                entry.kind <= ENTRY_OPERATOR;  // Operator wins a tie
            end else begin
                entry.kind <= ENTRY_EQUAL;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/operand_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_macros.svh"

module operand_memory
    import calc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    word_t mem [`CALC_MEM_DEPTH];
    word_t rd_data_q;
    logic  ack_q;
    logic  accept;

    // A held stb is taken once, the ack cycle blocks a second transfer
    assign accept = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;  // One cycle after stb
        end
    end

    // Storage and read port
    always_ff @(posedge clk) begin
        if (accept) begin
            if (wb_req.we) begin
                mem[wb_req.adr] <= wb_req.dat;
            end
            rd_data_q <= mem[wb_req.adr];  // Valid with the ack
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data_q;

endmodule

`default_nettype wire

// File: rtl/shift_add_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_macros.svh"

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t multiplicand,
    input  word_t multiplier,
    output word_t product,  // Low 16 bits of the full product
    output logic  done
);

    localparam int STEP_WIDTH = $clog2(`CALC_DATA_WIDTH);
    localparam logic [STEP_WIDTH-1:0] LAST_STEP = STEP_WIDTH'(`CALC_DATA_WIDTH - 1);

    word_t                 mcand_q;    // Shifts left each step
    word_t                 mplier_q;   // Shifts right, bit 0 decides
    word_t                 acc_q;
    logic [STEP_WIDTH-1:0] step_q;
    logic                  running_q;

    // Step sequencing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running_q <= 1'b0;
            step_q    <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running_q <= 1'b1;
                step_q    <= '0;
            end else if (running_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == LAST_STEP) begin
                    running_q <= 1'b0;
                    done      <= 1'b1;  // Product final on this edge
                end
            end
        end
    end

    // Datapath, carries out of bit 15 are dropped
    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
            acc_q    <= '0;
        end else if (running_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product = acc_q;

endmodule

`default_nettype wire

// File: rtl/arith_unit.sv
`timescale 1ns/10ps
`default_nettype none

module arith_unit
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  calc_op_t op,
    input  word_t    operand_a,
    input  word_t    operand_b,
    output word_t    result,
    output logic     finish
);

    word_t addsub_q;
    logic  addsub_done_q;
    logic  mul_start;
    word_t mul_product;
    logic  mul_done;

    assign mul_start = start && (op == OP_MUL);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addsub_done_q <= 1'b0;
        end else begin
            addsub_done_q <= start && (op != OP_MUL);  // One cycle result
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (op == OP_SUB) begin
                addsub_q <= operand_a - operand_b;  // Wraps below zero
            end else begin
                addsub_q <= operand_a + operand_b;
            end
        end
    end

    shift_add_multiplier u_mult (
        .clk          (clk),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (operand_a),
        .multiplier   (operand_b),
        .product      (mul_product),
        .done         (mul_done)
    );

    // Only one path can finish in a given cycle
    assign result = mul_done ? mul_product : addsub_q;
    assign finish = addsub_done_q || mul_done;

endmodule

`default_nettype wire

// File: rtl/calc_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_macros.svh"

module calc_control
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     entry_valid,
    input  entry_t   entry,
    input  wb_rsp_t  wb_rsp,
    output wb_req_t  wb_req,
    input  word_t    arith_result,
    input  logic     arith_finish,
    output logic     arith_start,
    output calc_op_t arith_op,       // Pending operator
    output word_t    arith_a,
    output word_t    arith_b,
    output logic     busy,
    output logic     complete,
    output word_t    display_value
);

    ctl_state_t state;
    logic       bus_ack;   // Current transfer finishes this cycle
    logic       bus_idle;  // No transfer open, free to raise one

    assign bus_ack  = wb_req.cyc && wb_rsp.ack;
    assign bus_idle = !wb_req.cyc;

    function automatic wb_req_t bus_open(logic we, mem_addr_t adr, word_t dat);
        wb_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        return req;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= GET_FIRST;
            wb_req        <= '0;
            arith_start   <= 1'b0;
            arith_op      <= OP_ADD;
            display_value <= '0;
        end else begin
            arith_start <= 1'b0;
            if (bus_ack) begin
                // Strobes drop in the cycle after ack, dat stays for the display
                wb_req.cyc <= 1'b0;
                wb_req.stb <= 1'b0;
                wb_req.we  <= 1'b0;
            end
            case (state)
                GET_FIRST: begin
                    if (entry_valid && entry.kind == ENTRY_OPERATOR) begin
                        arith_op <= entry.op;
                        wb_req   <= bus_open(1'b1, mem_addr_t'(`CALC_OPERAND_A_ADDR),
                                             entry.value);
                        state    <= WRITE_A;
                    end
                end
                WRITE_A: begin
                    if (bus_ack) state <= GET_SECOND;
                end
                GET_SECOND: begin
                    // A second operator is dropped along with its digits
                    if (entry_valid && entry.kind == ENTRY_EQUAL) begin
                        wb_req <= bus_open(1'b1, mem_addr_t'(`CALC_OPERAND_B_ADDR),
                                           entry.value);
                        state  <= WRITE_B;
                    end
                end
                WRITE_B: begin
                    if (bus_ack) state <= READ_A;
                end
                READ_A: begin
                    if (bus_ack) begin
                        state <= READ_B;
                    end else if (bus_idle) begin
                        wb_req <= bus_open(1'b0, mem_addr_t'(`CALC_OPERAND_A_ADDR), '0);
                    end
                end
                READ_B: begin
                    if (bus_ack) begin
                        arith_start <= 1'b1;  // Both operands valid next cycle
                        state       <= CALC;
                    end else if (bus_idle) begin
                        wb_req <= bus_open(1'b0, mem_addr_t'(`CALC_OPERAND_B_ADDR), '0);
                    end
                end
                CALC: begin
                    if (arith_finish) begin
                        wb_req <= bus_open(1'b1, mem_addr_t'(`CALC_RESULT_ADDR),
                                           arith_result);
                        state  <= WRITE_RESULT;
                    end
                end
                WRITE_RESULT: begin
                    if (bus_ack) begin
                        display_value <= wb_req.dat;
                        state         <= SHOW;
                    end
                end
                SHOW: begin
                    state <= GET_FIRST;
                end
                default: begin
                    state <= GET_FIRST;
                end
            endcase
        end
    end

    // Operands come only from memory reads
    always_ff @(posedge clk) begin
        if (bus_ack && state == READ_A) begin
            arith_a <= wb_rsp.dat;
        end
        if (bus_ack && state == READ_B) begin
            arith_b <= wb_rsp.dat;
        end
    end

    assign complete = (state == SHOW);
    assign busy     = (state != GET_FIRST) && (state != WRITE_A) && (state != GET_SECOND);

endmodule

`default_nettype wire

// File: rtl/calculator_top.sv
`timescale 1ns/10ps
`default_nettype none

module calculator_top
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     key_valid,
    input  digit_t   key_digit,
    input  logic     op_valid,
    input  calc_op_t op_code,
    input  logic     equal_valid,
    output word_t    display_value,
    output logic     complete,
    output logic     busy
);

    logic     entry_valid;
    entry_t   entry;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    word_t    arith_result;
    logic     arith_finish;
    logic     arith_start;
    calc_op_t arith_op;
    word_t    arith_a;
    word_t    arith_b;

    key_entry u_entry (
        .clk         (clk),
        .reset       (reset),
        .busy        (busy),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .equal_valid (equal_valid),
        .entry_valid (entry_valid),
        .entry       (entry)
    );

    calc_control u_control (
        .clk           (clk),
        .reset         (reset),
        .entry_valid   (entry_valid),
        .entry         (entry),
        .wb_rsp        (wb_rsp),
        .wb_req        (wb_req),
        .arith_result  (arith_result),
        .arith_finish  (arith_finish),
        .arith_start   (arith_start),
        .arith_op      (arith_op),
        .arith_a       (arith_a),
        .arith_b       (arith_b),
        .busy          (busy),
        .complete      (complete),
        .display_value (display_value)
    );

    operand_memory u_memory (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    arith_unit u_arith (
        .clk       (clk),
        .reset     (reset),
        .start     (arith_start),
        .op        (arith_op),
        .operand_a (arith_a),
        .operand_b (arith_b),
        .result    (arith_result),
        .finish    (arith_finish)
    );

endmodule

`default_nettype wire

// File: test/calculator_tb.sv
`timescale 1ns/10ps
`default_nettype none

module calculator_tb
    import calc_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_CALCS       = 40;   // Upper bound on calculations in the run
    localparam int CYCLES_PER_CALC = 200;
    localparam int RANDOM_ADDSUB   = 12;
    localparam int RANDOM_MUL      = 12;

    logic        clk;
    logic        reset;
    logic        key_valid;
    digit_t      key_digit;
    logic        op_valid;
    calc_op_t    op_code;
    logic        equal_valid;
    word_t       display_value;
    logic        complete;
    logic        busy;

    word_t       expected_q[$];  // Results waiting for a complete pulse
    digit_t      a_digits[$];
    digit_t      b_digits[$];

    calculator_top UUT (
        .clk           (clk),
        .reset         (reset),
        .key_valid     (key_valid),
        .key_digit     (key_digit),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .equal_valid   (equal_valid),
        .display_value (display_value),
        .complete      (complete),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected result, all arithmetic modulo 2^16
    function automatic word_t calc_model(word_t a, word_t b, calc_op_t op);
        logic [31:0] full;
        full = 32'(a) * 32'(b);
        case (op)
            OP_ADD:  return word_t'(a + b);
            OP_SUB:  return word_t'(a - b);
            default: return full[15:0];  // Low half of the product
        endcase
    endfunction

    function automatic word_t digits_value(digit_t digits[$]);
        int acc;
        acc = 0;
        foreach (digits[i]) begin
            acc = (acc * 10 + int'(digits[i])) % 65536;
        end
        return word_t'(acc);
    endfunction

    task automatic check_result(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %0d, expected %0d (controller in %s)",
                     $time, what, actual, expected, UUT.u_control.state.name());
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %b, expected %b (controller in %s)",
                     $time, what, actual, expected, UUT.u_control.state.name());
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One-cycle strobes followed by an idle cycle
    task automatic press_digit(digit_t d);
        @(negedge clk);
        key_valid = 1'b1;
        key_digit = d;
        @(negedge clk);
        key_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic press_operator(calc_op_t op);
        @(negedge clk);
        op_valid = 1'b1;
        op_code  = op;
        @(negedge clk);
        op_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic press_equal();
        @(negedge clk);
        equal_valid = 1'b1;
        @(negedge clk);
        equal_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic enter_number(digit_t digits[$]);
        foreach (digits[i]) begin
            press_digit(digits[i]);
        end
    endtask

    task automatic random_operands(int max_digits);
        int count;
        a_digits.delete();
        b_digits.delete();
        count = 1 + int'($urandom % max_digits);
        repeat (count) a_digits.push_back(digit_t'($urandom % 10));
        count = 1 + int'($urandom % max_digits);
        repeat (count) b_digits.push_back(digit_t'($urandom % 10));
    endtask

    // Busy must hold until the complete pulse and drop right after it
    task automatic wait_complete();
        @(negedge clk);
        while (!complete) begin
            check_flag(busy, 1'b1, "busy while calculating");
            @(negedge clk);
        end
        check_flag(busy, 1'b1, "busy during complete");
        @(negedge clk);
        check_flag(complete, 1'b0, "complete one cycle wide");
        check_flag(busy, 1'b0, "busy after complete");
    endtask

    task automatic run_calc(calc_op_t op);
        enter_number(a_digits);
        press_operator(op);
        enter_number(b_digits);
        expected_q.push_back(calc_model(digits_value(a_digits), digits_value(b_digits), op));
        press_equal();
        wait_complete();
    endtask

    // Stimulus
    initial begin
        void'($urandom(14));
        reset       = 1'b1;
        key_valid   = 1'b0;
        key_digit   = '0;
        op_valid    = 1'b0;
        op_code     = OP_ADD;
        equal_valid = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check_flag(complete, 1'b0, "complete after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_result(display_value, '0, "display after reset");

        a_digits = '{4'd1, 4'd2};
        b_digits = '{4'd3, 4'd4};
        run_calc(OP_ADD);
        a_digits = '{4'd7};
        b_digits = '{4'd9};
        run_calc(OP_SUB);  // Wraps to 65534
        a_digits = '{4'd1, 4'd0, 4'd0};
        b_digits = '{4'd2, 4'd0};
        run_calc(OP_SUB);

        repeat (RANDOM_ADDSUB) begin
            random_operands(4);
            run_calc(($urandom % 2) ? OP_SUB : OP_ADD);
        end
        repeat (RANDOM_MUL) begin
            random_operands(4);
            run_calc(OP_MUL);
        end

        // Six digits wrap during entry
        a_digits = '{4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd4};
        b_digits = '{4'd3};
        run_calc(OP_ADD);
        a_digits = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6};
        b_digits = '{4'd2};
        run_calc(OP_MUL);

        // Equal with no operator discards the digits, no result
        press_digit(4'd9);
        press_digit(4'd9);
        press_equal();
        repeat (50) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy after a lone equal key");
        end
        a_digits = '{4'd3};
        b_digits = '{4'd4};
        run_calc(OP_ADD);

        // Keys during a multiply are dropped
        a_digits = '{4'd2, 4'd5};
        b_digits = '{4'd1, 4'd3};
        enter_number(a_digits);
        press_operator(OP_MUL);
        enter_number(b_digits);
        expected_q.push_back(calc_model(digits_value(a_digits), digits_value(b_digits), OP_MUL));
        press_equal();
        check_flag(busy, 1'b1, "busy before keys in flight");
        press_digit(4'd7);
        press_operator(OP_SUB);
        press_equal();
        press_digit(4'd8);  // Would lead the next operand if taken
        wait_complete();
        a_digits = '{4'd4};
        b_digits = '{4'd5};
        run_calc(OP_ADD);

        // Second operator throws away 55, first operator stays
        a_digits = '{4'd6, 4'd1};
        b_digits = '{4'd2};
        enter_number(a_digits);
        press_operator(OP_SUB);
        press_digit(4'd5);
        press_digit(4'd5);
        press_operator(OP_ADD);
        enter_number(b_digits);
        expected_q.push_back(calc_model(digits_value(a_digits), digits_value(b_digits), OP_SUB));
        press_equal();
        wait_complete();

        repeat (10) @(negedge clk);
        if (expected_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d calculations never completed", expected_q.size());
            $display("Checks failed");
            $fatal(1, "Results still pending at the end");
        end
    end

    // Result and hold checks on every falling edge
    initial begin : result_checker
        word_t last_shown;
        word_t expected;
        last_shown = '0;
        wait (reset == 1'b0);
        forever begin
            @(negedge clk);
            if (complete) begin
                if (expected_q.size() == 0) begin
                    $display("A complete pulse arrived at %0t ns with no calculation pending",
                             $time);
                    $display("Checks failed");
                    $fatal(1, "Unexpected complete");
                end else begin
                    expected = expected_q.pop_front();
                    check_result(display_value, expected, "display on complete");
                    last_shown = display_value;
                end
            end else begin
                check_result(display_value, last_shown, "display hold");
            end
        end
    end

    initial begin : watchdog
        #(NUM_CALCS * CYCLES_PER_CALC * CLK_PERIOD);
        $display("The calculator stopped completing calculations (controller in %s)",
                 UUT.u_control.state.name());
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/calc_pkg.sv
rtl/key_entry.sv
rtl/operand_memory.sv
rtl/shift_add_multiplier.sv
rtl/arith_unit.sv
rtl/calc_control.sv
rtl/calculator_top.sv
test/calculator_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module calculator_tb -f tb.f -o calculator_sim

status=0
output=$(./obj_dir/calculator_sim 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "All checks passed"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
